// File: zx_trace.txt
# name op addr data | expected: ram_addr ram_we cpu_din border ear mic (all hex)
# op: MR/MW memory read/write, IR/IW I/O read/write, RS reset, MD set model_48 then reset
rst_rom0     MR 0123 5A 20123 0 5A 0 0 0
rst_scr      MR 4567 A5 14567 0 A5 0 0 0
rst_mid      MR 8ABC 3C 08ABC 0 3C 0 0 0
rst_top      MR C123 C3 00123 0 C3 0 0 0
io_idle      IR 00FF 1F 200FF 0 FF 0 0 0
pg_ram7      IW 7FFD 07 17FFD 0 FF 0 0 0
pg_top7      MR C010 11 1C010 0 11 0 0 0
pg_rom1      IW 7FFD 17 17FFD 0 FF 0 0 0
pg_rom1_rd   MR 0010 22 24010 0 22 0 0 0
pg_lock      IW 7FFD 23 17FFD 0 FF 0 0 0
pg_lock_top  MR C000 44 0C000 0 44 0 0 0
pg_lock_wr   IW 7FFD 06 17FFD 0 FF 0 0 0
pg_still3    MR C000 66 0C000 0 66 0 0 0
pg_reset     RS C000 00 00000 0 FF 0 0 0
mw_rom       MW 1234 AA 21234 0 FF 0 0 0
mw_scr       MW 4321 BB 14321 1 FF 0 0 0
mw_mid       MW 8765 CC 08765 1 FF 0 0 0
mw_top       MW C0DE DD 000DE 1 FF 0 0 0
fe_wr        IW 00FE 1D 200FE 0 FF 5 1 1
fe_wr2       IW FFFE 0A 03FFE 0 FF 2 0 1
fe_rd        IR 00FE 2A 200FE 0 AA 2 0 1
fe_rd_tape0  IR 00FE 15 200FE 0 F5 2 0 1
fe_reset     RS 00FE 00 200FE 0 FF 0 0 0
m48_on       MD 0000 01 24000 0 FF 0 0 0
m48_wr       IW 7FFD 07 17FFD 0 FF 0 0 0
m48_top      MR C000 34 00000 0 34 0 0 0

// File: verilog.f
+incdir+.
zx_pkg.sv
zx_bus_if.sv
zx_bus_decode.sv
zx_page_regs.sv
zx_mem_map.sv
zx_ula.sv
zx_bus_top.sv
tb_zx_bus.sv

// File: Bender.yml
package:
  name: zx_bus

sources:
  - include_dirs:
      - .
    files:
      - zx_pkg.sv
      - zx_bus_if.sv
      - zx_bus_decode.sv
      - zx_page_regs.sv
      - zx_mem_map.sv
      - zx_ula.sv
      - zx_bus_top.sv
      - target: test
        files:
          - tb_zx_bus.sv

// File: tb_zx_bus.sv
// Spectrum bus testbench
`include "zx_config.svh"

module tb_zx_bus;

	timeunit 1ns;
	timeprecision 1ps;

	logic                      clk_sys;
	logic                      reset;
	logic                      model_48;
	logic [`ZX_ADDR_W-1:0]     addr;
	logic [`ZX_DATA_W-1:0]     cpu_dout;
	logic                      mreq;
	logic                      iorq;
	logic                      rd;
	logic                      wr;
	logic                      m1;
	logic [`ZX_DATA_W-1:0]     cpu_din;
	logic [4:0]                key_data;
	logic                      tape_in;
	logic [`ZX_MEM_ADDR_W-1:0] ram_addr;
	logic                      ram_rd;
	logic                      ram_we;
	logic [`ZX_DATA_W-1:0]     ram_dout;
	logic [2:0]                border_color;
	logic                      ear_out;
	logic                      mic_out;

	// Current trace line
	string       name;
	string       op;
	logic [31:0] t_addr;
	logic [31:0] t_data;
	logic [31:0] e_addr;
	logic [31:0] e_we;
	logic [31:0] e_din;
	logic [31:0] e_border;
	logic [31:0] e_ear;
	logic [31:0] e_mic;
	int          n_lines;
	bit          trace_ready;

	zx_bus_top dut (.*);

	always #4 clk_sys = ~clk_sys;

	// ============================================================
	// Helpers
	// ============================================================
	task automatic abort_run(input string why);
		if (why.len() > 0)
			$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic compare_value(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR %s %s: expected %0h, actual %0h", name, field, expected, actual);
			abort_run("");
		end
	endtask

	task automatic check_outputs();
		logic [31:0] e_rd;

		// Read strobe only while a memory read is held
		e_rd = (op == "MR") ? 32'd1 : 32'd0;
		compare_value("ram_addr", e_addr, 32'(ram_addr));
		compare_value("ram_we", e_we, 32'(ram_we));
		compare_value("ram_rd", e_rd, 32'(ram_rd));
		compare_value("cpu_din", e_din, 32'(cpu_din));
		compare_value("border_color", e_border, 32'(border_color));
		compare_value("ear_out", e_ear, 32'(ear_out));
		compare_value("mic_out", e_mic, 32'(mic_out));
	endtask

	task automatic release_strobes();
		mreq = 1'b0;
		iorq = 1'b0;
		rd   = 1'b0;
		wr   = 1'b0;
		m1   = 1'b0;
	endtask

	// Starts and ends on a falling edge
	task automatic apply_reset();
		reset = 1'b1;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	function automatic bit is_data_line(input string text);
		return text.len() > 1 && text.getc(0) != "#";
	endfunction

	// One bus operation, memory cycles checked while held
	task automatic run_op();
		addr = t_addr[15:0];
		case (op)
			"MR": begin
				ram_dout = t_data[7:0];
				mreq = 1'b1;
				rd   = 1'b1;
				@(negedge clk_sys);
				check_outputs();
			end
			"IR": begin
				tape_in  = t_data[5];
				key_data = t_data[4:0];
				iorq = 1'b1;
				rd   = 1'b1;
				@(negedge clk_sys);
				check_outputs();
			end
			"MW": begin
				cpu_dout = t_data[7:0];
				mreq = 1'b1;
				wr   = 1'b1;
				repeat (2) @(negedge clk_sys);
				check_outputs();
			end
			"IW": begin
				cpu_dout = t_data[7:0];
				iorq = 1'b1;
				wr   = 1'b1;
				@(negedge clk_sys);
				// Other data in the second cycle, a repeated write would latch it
				cpu_dout = ~t_data[7:0];
				@(negedge clk_sys);
				release_strobes();
				@(negedge clk_sys);
				check_outputs();
			end
			"RS": begin
				apply_reset();
				check_outputs();
			end
			"MD": begin
				model_48 = t_data[0];
				apply_reset();
				check_outputs();
			end
			default: abort_run({"unknown operation ", op, " in test ", name});
		endcase
		release_strobes();
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		int    fd;
		int    code;
		string line;

		clk_sys  = 1'b0;
		reset    = 1'b1;
		model_48 = 1'b0;
		addr     = '0;
		cpu_dout = '0;
		key_data = 5'h1F;
		tape_in  = 1'b0;
		ram_dout = '0;
		release_strobes();

		// Count operations first for the watchdog
		fd = $fopen("zx_trace.txt", "r");
		if (fd == 0)
			abort_run("cannot open zx_trace.txt");
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code != 0 && is_data_line(line))
				n_lines++;
		end
		$fclose(fd);
		trace_ready = 1'b1;

		apply_reset();

		fd = $fopen("zx_trace.txt", "r");
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code != 0 && is_data_line(line)) begin
				code = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h", name, op,
					t_addr, t_data, e_addr, e_we, e_din, e_border, e_ear, e_mic);
				if (code != 10)
					abort_run({"malformed trace line: ", line});
				run_op();
			end
		end
		$fclose(fd);

		$display("sim passed");
		$finish;
	end

	// Six cycles per operation is more than the longest one needs
	initial begin
		wait (trace_ready);
		#(n_lines * 6 * 8 + 200);
		abort_run("watchdog expired before the trace finished");
	end

endmodule

// File: zx_bus_top.sv
// Spectrum 128K bus logic top
`include "zx_config.svh"

module zx_bus_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      model_48,
	// CPU bus, active high strobes
	input  logic [`ZX_ADDR_W-1:0]     addr,
	input  logic [`ZX_DATA_W-1:0]     cpu_dout,
	input  logic                      mreq,
	input  logic                      iorq,
	input  logic                      rd,
	input  logic                      wr,
	input  logic                      m1,
	output logic [`ZX_DATA_W-1:0]     cpu_din,
	// Keyboard and tape
	input  logic [4:0]                key_data,
	input  logic                      tape_in,
	// Flat memory
	output logic [`ZX_MEM_ADDR_W-1:0] ram_addr,
	output logic                      ram_rd,
	output logic                      ram_we,
	input  logic [`ZX_DATA_W-1:0]     ram_dout,
	// ULA outputs
	output logic [2:0]                border_color,
	output logic                      ear_out,
	output logic                      mic_out
);

	import zx_pkg::*;

	zx_page_state_t page_state;

	zx_bus_if bus ();

	zx_bus_decode u_decode (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.addr     (addr),
		.cpu_dout (cpu_dout),
		.mreq     (mreq),
		.iorq     (iorq),
		.rd       (rd),
		.wr       (wr),
		.m1       (m1),
		.bus      (bus.source)
	);

	zx_page_regs u_page_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.model_48   (model_48),
		.bus        (bus.sink),
		.page_state (page_state)
	);

	zx_mem_map u_mem_map (
		.bus        (bus.sink),
		.page_state (page_state),
		.ram_addr   (ram_addr),
		.ram_rd     (ram_rd),
		.ram_we     (ram_we)
	);

	zx_ula u_ula (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus.sink),
		.key_data     (key_data),
		.tape_in      (tape_in),
		.ram_dout     (ram_dout),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out),
		.cpu_din      (cpu_din)
	);

endmodule

// File: zx_ula.sv
// ULA port and CPU read data
`include "zx_config.svh"

module zx_ula (
	input  logic                  clk_sys,
	input  logic                  reset,
	zx_bus_if.sink                bus,
	input  logic [4:0]            key_data,
	input  logic                  tape_in,
	input  logic [`ZX_DATA_W-1:0] ram_dout,
	output logic [2:0]            border_color,
	output logic                  ear_out,
	output logic                  mic_out,
	output logic [`ZX_DATA_W-1:0] cpu_din
);

	logic ula_port;

	// Any even port address reaches the ULA
	assign ula_port = ~bus.addr[0];

	// ============================================================
	// Port FE write latch
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			mic_out      <= 1'b0;
			ear_out      <= 1'b0;
		end else if (bus.io_wr_pulse && ula_port) begin
			border_color <= bus.wdata[2:0];
			mic_out      <= bus.wdata[3];
			ear_out      <= bus.wdata[4];
		end
	end

	// ============================================================
	// CPU read data
	// ============================================================
	always_comb begin
		if (bus.mem_rd) begin
			cpu_din = ram_dout;
		end else if (bus.io_rd && ula_port) begin
			// Keyboard row in the low bits, tape on bit 6
			cpu_din = {1'b1, ~tape_in, 1'b1, key_data};
		end else begin
			// Floating bus
			cpu_din = `ZX_IDLE_DATA;
		end
	end

endmodule

// File: zx_mem_map.sv
// CPU to flat memory mapping
`include "zx_config.svh"

module zx_mem_map (
	zx_bus_if.sink                    bus,
	input  zx_pkg::zx_page_state_t    page_state,
	output logic [`ZX_MEM_ADDR_W-1:0] ram_addr,
	output logic                      ram_rd,
	output logic                      ram_we
);

	import zx_pkg::*;

	zx_bank_t bank;
	logic     rom_quarter;

	// ============================================================
	// Bank select and strobes
	// ============================================================
	always_comb begin
		rom_quarter = (bus.addr[15:14] == 2'b00);

		case (bus.addr[15:14])
			// ROM 0 or ROM 1
			2'b00:   bank = `ZX_BANK_ROM0 + {3'b000, page_state.rom_sel};
			// Screen bank, fixed
			2'b01:   bank = `ZX_BANK_SCREEN;
			2'b10:   bank = `ZX_BANK_MID;
			// Paged RAM
			default: bank = {1'b0, page_state.ram_page};
		endcase

		ram_addr = {bank, bus.addr[13:0]};
		ram_rd   = bus.mem_rd;

		// ROM is write protected
		ram_we = bus.mem_wr & ~rom_quarter;
	end

endmodule

// File: zx_page_regs.sv
// 128K paging register
`include "zx_config.svh"

module zx_page_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   model_48,
	zx_bus_if.sink                 bus,
	output zx_pkg::zx_page_state_t page_state
);

	import zx_pkg::*;

	// Fixed 48K layout, ROM 1 and no paging
	localparam zx_page_state_t page_48k = '{
		ram_page: 3'd0,
		rom_sel:  1'b1,
		scr_page: 1'b0,
		locked:   1'b1
	};

	zx_page_state_t state_q;
	logic           port_7ffd;
	logic           page_wr;

	// ============================================================
	// Port 7FFD decode
	// ============================================================

	// Partial decode, A15 and A1 low
	assign port_7ffd = ~bus.addr[15] & ~bus.addr[1];

	// Lock and 48K mode both block the write
	assign page_wr = bus.io_wr_pulse & port_7ffd & ~state_q.locked & ~model_48;

	// ============================================================
	// Register
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state_q.ram_page <= 3'd0;
			state_q.scr_page <= 1'b0;
			state_q.rom_sel  <= model_48;
			state_q.locked   <= model_48;
		end else if (page_wr) begin
			state_q.ram_page <= bus.wdata[2:0];
			state_q.scr_page <= bus.wdata[3];
			state_q.rom_sel  <= bus.wdata[4];
			// Only reset clears the lock again
			state_q.locked   <= bus.wdata[5];
		end
	end

	// Model input may change without a reset in between
	assign page_state = model_48 ? page_48k : state_q;

	// Once locked, nothing but reset touches the paging state
	locked_stable: assert property (@(posedge clk_sys) disable iff (reset)
		state_q.locked |=> $stable(state_q))
		else $error("paging state changed while locked");

endmodule

// File: zx_bus_decode.sv
// CPU strobe decoder
`include "zx_config.svh"

module zx_bus_decode (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [`ZX_ADDR_W-1:0] addr,
	input  logic [`ZX_DATA_W-1:0] cpu_dout,
	input  logic                  mreq,
	input  logic                  iorq,
	input  logic                  rd,
	input  logic                  wr,
	input  logic                  m1,
	zx_bus_if.source              bus
);

	logic io_wr_lvl;
	logic io_wr_prev;

	assign bus.addr  = addr;
	assign bus.wdata = cpu_dout;

	// ============================================================
	// Cycle levels
	// ============================================================
	assign bus.mem_rd = mreq & rd;
	assign bus.mem_wr = mreq & wr;

	// IORQ with M1 is an interrupt acknowledge, not a port access
	assign bus.io_rd = iorq & rd & ~m1;
	assign io_wr_lvl = iorq & wr & ~m1;

	// ============================================================
	// Write pulse, first cycle of the level only
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_prev <= 1'b0;
		end else begin
			io_wr_prev <= io_wr_lvl;
		end
	end

	assign bus.io_wr_pulse = io_wr_lvl & ~io_wr_prev;

	// Z80 never reads and writes memory in one cycle
	mem_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(bus.mem_rd && bus.mem_wr))
		else $error("memory read and write strobes high together");

endmodule

// File: zx_bus_if.sv
// Decoded CPU bus
`include "zx_config.svh"

interface zx_bus_if;

	// Copies of the raw CPU bus
	logic [`ZX_ADDR_W-1:0] addr;
	logic [`ZX_DATA_W-1:0] wdata;

	// Memory cycle levels
	logic mem_rd;
	logic mem_wr;

	// I/O read level, interrupt acknowledge excluded
	logic io_rd;

	// One cycle at the start of an I/O write
	logic io_wr_pulse;

	modport source (
		output addr, wdata, mem_rd, mem_wr, io_rd, io_wr_pulse
	);

	modport sink (
		input addr, wdata, mem_rd, mem_wr, io_rd, io_wr_pulse
	);

endinterface

// File: zx_pkg.sv
// Spectrum bus types
package zx_pkg;

	// ============================================================
	// Banks of the flat memory
	// ============================================================

	// 0..7 are RAM, 8..9 are ROM
	typedef logic [3:0] zx_bank_t;

	// ============================================================
	// Paging state
	// ============================================================

	// Contents of port 7FFD as seen by the memory map
	typedef struct packed {
		// Bank at C000-FFFF
		logic [2:0] ram_page;
		// ROM number at 0000-3FFF
		logic       rom_sel;
		// Screen page, for the video side
		logic       scr_page;
		// Paging disabled until reset
		logic       locked;
	} zx_page_state_t;

endpackage

// File: zx_config.svh
// Spectrum bus configuration
`ifndef ZX_CONFIG_SVH
`define ZX_CONFIG_SVH

// ============================================================
// Bus widths
// ============================================================
`define ZX_ADDR_W     16
`define ZX_DATA_W     8
// 4-bit bank above a 14-bit offset
`define ZX_MEM_ADDR_W 18

// ============================================================
// Fixed banks and idle bus value
// ============================================================
// ROM 0, ROM 1 follows it
`define ZX_BANK_ROM0   4'd8
`define ZX_BANK_SCREEN 4'd5
`define ZX_BANK_MID    4'd2
// Value seen on unclaimed I/O reads
`define ZX_IDLE_DATA   8'hFF

`endif
